/* verilog/ahb_matrix_params.svh */
// Widths and port count for the shared-slave output stage
// NUM_PORTS is fixed at 4 because the arbiter priority chain is wired for it
`ifndef AHB_MATRIX_PARAMS_SVH
`define AHB_MATRIX_PARAMS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define AHB_ADDR_W 32 // HADDR width
`define AHB_DATA_W 32 // HWDATA width
`define AHB_SIZE_W 3  // HSIZE width

// ----------------------------------------
// Input stage count
// ----------------------------------------
`define NUM_PORTS  4  // Input stages sharing the slave
`define PORT_IDX_W 2  // Enough bits to index NUM_PORTS

`endif

/* verilog/ahb_matrix_pkg.sv */
// Shared types for the output stage
// Encodings match the AHB HTRANS field
`default_nettype none

`include "ahb_matrix_params.svh"

package ahb_matrix_pkg;

  // AHB transfer type
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00, // No transfer wanted
    BUSY   = 2'b01, // Master pauses inside a burst
    NONSEQ = 2'b10, // Single or first beat
    SEQ    = 2'b11  // Following burst beat
  } htrans_t;

  // Index of one input stage
  typedef logic [`PORT_IDX_W-1:0] port_idx_t;

endpackage

`default_nettype wire

/* verilog/output_arbiter.sv */
// Port 0 has the highest priority and the chain below is wired for 4 ports
// Grant updates only on ready edges, one cycle after the deciding request
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_params.svh"

module output_arbiter
  import ahb_matrix_pkg::*;
(
  input  logic      HCLK,                        // AHB clock
  input  logic      HRESETn,                     // Sync reset, active low
  input  logic      i_sel_op       [`NUM_PORTS], // Per-port HSEL
  input  logic      i_held_tran_op [`NUM_PORTS], // Per-port pending transfer
  input  htrans_t   i_trans_op     [`NUM_PORTS], // Per-port HTRANS
  input  logic      i_sel_m,                     // Muxed HSEL of granted port
  input  htrans_t   i_trans_m,                   // Muxed HTRANS
  input  logic      i_mastlock_m,                // Muxed HMASTLOCK
  input  logic      i_hready_mux,                // HREADYMUXM feedback
  output port_idx_t o_grant_port,                // Registered grant
  output logic      o_no_port                    // No port owns the slave
);

  logic [`NUM_PORTS-1:0] req;      // Qualified requests
  port_idx_t             grant_port;
  logic                  no_port;
  port_idx_t             winner;   // Lowest requesting port
  logic                  any_req;
  logic                  lock_arb; // Lock masked by select
  logic                  hold_grant;
  logic                  hsel_lock;
  logic                  next_hsel_lock;
  logic                  addr_xfer;

  // ----------------------------------------
  // Request qualification
  // ----------------------------------------
  always_comb
  begin
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      req[i] = i_held_tran_op[i] & i_sel_op[i]; // Pending and aimed here
    end
  end

  assign any_req = |req;

  // Fixed priority chain
  always_comb
  begin
    winner = grant_port; // Unused when nobody asks
    if (req[0])
      winner = port_idx_t'(0);
    else if (req[1])
      winner = port_idx_t'(1);
    else if (req[2])
      winner = port_idx_t'(2);
    else if (req[3])
      winner = port_idx_t'(3);
  end

  // ----------------------------------------
  // Burst and lock hold
  // ----------------------------------------
  assign lock_arb = i_mastlock_m & (hsel_lock | i_sel_m);

  // Owner keeps the slave mid-burst or while locked
  assign hold_grant = ~no_port & req[grant_port] &
                      ((i_trans_op[grant_port] == SEQ) |
                       (i_trans_op[grant_port] == BUSY) | lock_arb);

  assign addr_xfer = (i_trans_m == NONSEQ) | (i_trans_m == SEQ);

  // Remembers a locked sequence while HSEL briefly drops
  always_comb
  begin
    if (i_sel_m & addr_xfer & i_mastlock_m)
      next_hsel_lock = 1'b1; // Locked beat reached slave
    else if (!i_mastlock_m)
      next_hsel_lock = 1'b0; // Lock released
    else
      next_hsel_lock = hsel_lock;
  end

  // ----------------------------------------
  // Grant register
  // ----------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      grant_port <= '0;
      no_port    <= 1'b1;
      hsel_lock  <= 1'b0;
    end
    else if (i_hready_mux)
    begin
      hsel_lock <= next_hsel_lock;
      if (!hold_grant)
      begin
        if (any_req)
        begin
          grant_port <= winner;
          no_port    <= 1'b0;
        end
        else
          no_port <= 1'b1; // Grant value kept, just parked
      end
    end
  end

  assign o_grant_port = grant_port;
  assign o_no_port    = no_port;

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // Wait state on slave freezes arbitration
  a_grant_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !i_hready_mux |=> ($stable(grant_port) && $stable(no_port)))
    else $error("output_arbiter: grant moved during wait state");

  // Whoever holds the slave asked for it at the deciding edge
  a_grant_requested: assert property (@(posedge HCLK) disable iff (!HRESETn)
    i_hready_mux |=> (no_port || (($past(req) & (`NUM_PORTS'(1) << grant_port)) != '0)))
    else $error("output_arbiter: port granted without a request");

endmodule

`default_nettype wire

/* verilog/addr_phase_mux.sv */
// Purely combinational; all outputs are zero while no port is granted
// Only HSEL, HADDR, HTRANS, HWRITE, HSIZE and HMASTLOCK reach the slave
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_params.svh"

module addr_phase_mux
  import ahb_matrix_pkg::*;
(
  input  port_idx_t              i_grant_port,                // From arbiter
  input  logic                   i_no_port,                   // Nobody granted
  input  logic                   i_sel_op      [`NUM_PORTS],  // Per-port HSEL
  input  logic [`AHB_ADDR_W-1:0] i_addr_op     [`NUM_PORTS],  // Per-port HADDR
  input  htrans_t                i_trans_op    [`NUM_PORTS],  // Per-port HTRANS
  input  logic                   i_write_op    [`NUM_PORTS],  // Per-port HWRITE
  input  logic [`AHB_SIZE_W-1:0] i_size_op     [`NUM_PORTS],  // Per-port HSIZE
  input  logic                   i_mastlock_op [`NUM_PORTS],  // Per-port HMASTLOCK
  output logic                   o_hselm,                     // Slave select
  output logic [`AHB_ADDR_W-1:0] o_haddrm,                    // Slave address
  output htrans_t                o_htransm,                   // Slave transfer type
  output logic                   o_hwritem,                   // Slave direction
  output logic [`AHB_SIZE_W-1:0] o_hsizem,                    // Slave size
  output logic                   o_hmastlockm,                // Slave lock
  output logic [`NUM_PORTS-1:0]  o_active_op                  // Per-port owner flag
);

  // ----------------------------------------
  // Address and control select
  // ----------------------------------------
  always_comb
  begin
    o_hselm      = 1'b0; // Quiet bus by default
    o_haddrm     = '0;
    o_htransm    = IDLE;
    o_hwritem    = 1'b0;
    o_hsizem     = '0;
    o_hmastlockm = 1'b0;
    if (!i_no_port)
    begin
      o_hselm      = i_sel_op[i_grant_port];
      o_haddrm     = i_addr_op[i_grant_port];
      o_htransm    = i_trans_op[i_grant_port];
      o_hwritem    = i_write_op[i_grant_port];
      o_hsizem     = i_size_op[i_grant_port];
      o_hmastlockm = i_mastlock_op[i_grant_port];
    end
  end

  // ----------------------------------------
  // Active decode
  // ----------------------------------------
  // Tells each input stage that its transfer sits on the slave
  always_comb
  begin
    o_active_op = '0;
    if (!i_no_port)
      o_active_op[i_grant_port] = 1'b1; // Single owner
  end

  // At most one owner, and a selected slave always has one
  always_comb
  begin
    if (!$isunknown(i_no_port))
    begin
      a_active_onehot: assert ($onehot0(o_active_op) && (!o_hselm || (o_active_op != '0)))
        else $error("addr_phase_mux: active vector not one-hot or select without owner");
    end
  end

endmodule

`default_nettype wire

/* verilog/data_phase_stage.sv */
// Write data trails its address phase by one accepted transfer
// HWDATAM is forced to zero in idle data phases to save toggling
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_params.svh"

module data_phase_stage
  import ahb_matrix_pkg::*;
(
  input  logic                   HCLK,                    // AHB clock
  input  logic                   HRESETn,                 // Sync reset, active low
  input  port_idx_t              i_grant_port,            // Address-phase owner
  input  logic                   i_sel_m,                 // Muxed HSEL
  input  htrans_t                i_trans_m,               // Muxed HTRANS
  input  logic [`AHB_DATA_W-1:0] i_wdata_op [`NUM_PORTS], // Per-port HWDATA
  input  logic                   i_hreadyoutm,            // Slave HREADYOUT
  output logic [`AHB_DATA_W-1:0] o_hwdatam,               // Slave write data
  output logic                   o_hready_mux             // HREADYMUXM
);

  port_idx_t data_port;   // Data-phase owner
  logic      wdata_phase; // Real transfer in data phase
  logic      slave_sel;   // Slave addressed last phase
  logic      addr_xfer;   // NONSEQ or SEQ to this slave
  logic      hready_mux;

  assign addr_xfer = i_sel_m & ((i_trans_m == NONSEQ) | (i_trans_m == SEQ));

  // ----------------------------------------
  // Data-phase registers
  // ----------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port   <= '1; // Port 3 after reset
      wdata_phase <= 1'b0;
      slave_sel   <= 1'b0;
    end
    else if (hready_mux)
    begin
      data_port   <= i_grant_port; // Address phase becomes data phase
      wdata_phase <= addr_xfer;
      slave_sel   <= i_sel_m;
    end
  end

  // ----------------------------------------
  // HREADYMUXM generation
  // ----------------------------------------
  // Slave drives ready only while it owns the data phase
  assign hready_mux   = slave_sel ? i_hreadyoutm : 1'b1;
  assign o_hready_mux = hready_mux;

  // Write data mux
  always_comb
  begin
    o_hwdatam = '0;
    if (wdata_phase)
      o_hwdatam = i_wdata_op[data_port];
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  // Accepted idle address phase leaves a silent data bus
  a_wdata_idle_zero: assert property (@(posedge HCLK) disable iff (!HRESETn)
    (hready_mux && !addr_xfer) |=> (o_hwdatam == '0))
    else $error("data_phase_stage: write data toggles in idle data phase");

endmodule

`default_nettype wire

/* verilog/ahb_output_stage.sv */
// Output stage for one shared slave fed by 4 input stages
// HBURST, HPROT and HMASTER are not routed; arbitration uses HTRANS only
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_params.svh"

module ahb_output_stage
  import ahb_matrix_pkg::*;
(
  input  logic                   HCLK,                         // AHB clock
  input  logic                   HRESETn,                      // Sync reset, active low
  input  logic                   i_sel_op       [`NUM_PORTS],  // Per-port HSEL
  input  logic [`AHB_ADDR_W-1:0] i_addr_op      [`NUM_PORTS],  // Per-port HADDR
  input  htrans_t                i_trans_op     [`NUM_PORTS],  // Per-port HTRANS
  input  logic                   i_write_op     [`NUM_PORTS],  // Per-port HWRITE
  input  logic [`AHB_SIZE_W-1:0] i_size_op      [`NUM_PORTS],  // Per-port HSIZE
  input  logic                   i_mastlock_op  [`NUM_PORTS],  // Per-port HMASTLOCK
  input  logic [`AHB_DATA_W-1:0] i_wdata_op     [`NUM_PORTS],  // Per-port HWDATA
  input  logic                   i_held_tran_op [`NUM_PORTS],  // Per-port pending flag
  input  logic                   i_hreadyoutm,                 // Slave HREADYOUT
  output logic [`NUM_PORTS-1:0]  o_active_op,                  // Per-port owner flag
  output logic                   o_hselm,                      // Slave select
  output logic [`AHB_ADDR_W-1:0] o_haddrm,                     // Slave address
  output htrans_t                o_htransm,                    // Slave transfer type
  output logic                   o_hwritem,                    // Slave direction
  output logic [`AHB_SIZE_W-1:0] o_hsizem,                     // Slave size
  output logic                   o_hmastlockm,                 // Slave lock
  output logic                   o_hreadymuxm,                 // Slave-side HREADY
  output logic [`AHB_DATA_W-1:0] o_hwdatam                     // Slave write data
);

  port_idx_t grant_port; // Address-phase owner
  logic      no_port;    // Slave unowned

  // ----------------------------------------
  // Arbitration
  // ----------------------------------------
  output_arbiter u_output_arbiter (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_sel_op       (i_sel_op),
    .i_held_tran_op (i_held_tran_op),
    .i_trans_op     (i_trans_op),
    .i_sel_m        (o_hselm),      // Fed back from mux
    .i_trans_m      (o_htransm),
    .i_mastlock_m   (o_hmastlockm),
    .i_hready_mux   (o_hreadymuxm),
    .o_grant_port   (grant_port),
    .o_no_port      (no_port)
  );

  // Address phase
  addr_phase_mux u_addr_phase_mux (
    .i_grant_port  (grant_port),
    .i_no_port     (no_port),
    .i_sel_op      (i_sel_op),
    .i_addr_op     (i_addr_op),
    .i_trans_op    (i_trans_op),
    .i_write_op    (i_write_op),
    .i_size_op     (i_size_op),
    .i_mastlock_op (i_mastlock_op),
    .o_hselm       (o_hselm),
    .o_haddrm      (o_haddrm),
    .o_htransm     (o_htransm),
    .o_hwritem     (o_hwritem),
    .o_hsizem      (o_hsizem),
    .o_hmastlockm  (o_hmastlockm),
    .o_active_op   (o_active_op)
  );

  // Data phase
  data_phase_stage u_data_phase_stage (
    .HCLK         (HCLK),
    .HRESETn      (HRESETn),
    .i_grant_port (grant_port),
    .i_sel_m      (o_hselm),
    .i_trans_m    (o_htransm),
    .i_wdata_op   (i_wdata_op),
    .i_hreadyoutm (i_hreadyoutm),
    .o_hwdatam    (o_hwdatam),
    .o_hready_mux (o_hreadymuxm)    // Also back to arbiter
  );

endmodule

`default_nettype wire

/* tests/tb_output_stage.sv */
// Self-checking testbench for the shared-slave output stage
// Expected values come from a cycle model of the arbitration and data-phase rules
// Masters hold their address and control during wait states
`timescale 1ns/1ps
`default_nettype none

`include "ahb_matrix_params.svh"

module tb_output_stage
  import ahb_matrix_pkg::*;
();

  localparam int RAND_CYCLES    = 360;               // Random traffic length
  localparam int TEST_CYCLES    = 60 + RAND_CYCLES;  // Reset, directed tests, random test
  localparam int TIMEOUT_CYCLES = TEST_CYCLES * 3 / 2;

  logic                   HCLK;
  logic                   HRESETn;
  logic                   i_sel_op       [`NUM_PORTS];
  logic [`AHB_ADDR_W-1:0] i_addr_op      [`NUM_PORTS];
  htrans_t                i_trans_op     [`NUM_PORTS];
  logic                   i_write_op     [`NUM_PORTS];
  logic [`AHB_SIZE_W-1:0] i_size_op      [`NUM_PORTS];
  logic                   i_mastlock_op  [`NUM_PORTS];
  logic [`AHB_DATA_W-1:0] i_wdata_op     [`NUM_PORTS];
  logic                   i_held_tran_op [`NUM_PORTS];
  logic                   i_hreadyoutm;
  logic [`NUM_PORTS-1:0]  o_active_op;
  logic                   o_hselm;
  logic [`AHB_ADDR_W-1:0] o_haddrm;
  htrans_t                o_htransm;
  logic                   o_hwritem;
  logic [`AHB_SIZE_W-1:0] o_hsizem;
  logic                   o_hmastlockm;
  logic                   o_hreadymuxm;
  logic [`AHB_DATA_W-1:0] o_hwdatam;

  // Cycle model registers
  port_idx_t m_grant;
  logic      m_no_port;
  logic      m_hsel_lock;
  port_idx_t m_data_port;
  logic      m_wdata_phase;
  logic      m_slave_sel;

  // Expected outputs
  logic                   exp_hselm;
  logic [`AHB_ADDR_W-1:0] exp_haddrm;
  htrans_t                exp_htransm;
  logic                   exp_hwritem;
  logic [`AHB_SIZE_W-1:0] exp_hsizem;
  logic                   exp_hmastlockm;
  logic [`NUM_PORTS-1:0]  exp_active;
  logic                   exp_hready;
  logic [`AHB_DATA_W-1:0] exp_hwdatam;

  int                     seed          = 32'h7301;
  int                     err_cnt       = 0;
  int                     test_cnt      = 0;
  int                     fail_cnt      = 0;
  int                     test_err_base = 0;
  int                     cycle_cnt     = 0;
  logic                   check_en      = 1'b0; // Compare only after reset
  logic                   have_prev     = 1'b0;
  logic                   smp_ready;              // Ready seen by stimulus
  logic                   prev_ready;
  logic [`AHB_ADDR_W-1:0] prev_addr;
  htrans_t                prev_trans;
  logic [`NUM_PORTS-1:0]  prev_active;

  ahb_output_stage i_ahb_output_stage (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_sel_op       (i_sel_op),
    .i_addr_op      (i_addr_op),
    .i_trans_op     (i_trans_op),
    .i_write_op     (i_write_op),
    .i_size_op      (i_size_op),
    .i_mastlock_op  (i_mastlock_op),
    .i_wdata_op     (i_wdata_op),
    .i_held_tran_op (i_held_tran_op),
    .i_hreadyoutm   (i_hreadyoutm),
    .o_active_op    (o_active_op),
    .o_hselm        (o_hselm),
    .o_haddrm       (o_haddrm),
    .o_htransm      (o_htransm),
    .o_hwritem      (o_hwritem),
    .o_hsizem       (o_hsizem),
    .o_hmastlockm   (o_hmastlockm),
    .o_hreadymuxm   (o_hreadymuxm),
    .o_hwdatam      (o_hwdatam)
  );

  initial
  begin
    HCLK = 1'b0;
    forever #2 HCLK = ~HCLK; // 4 ns period
  end

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  // Outputs from model registers and the driven inputs
  function automatic void reference_outputs();
    exp_hselm      = 1'b0; // Parked slave sees a quiet bus
    exp_haddrm     = '0;
    exp_htransm    = IDLE;
    exp_hwritem    = 1'b0;
    exp_hsizem     = '0;
    exp_hmastlockm = 1'b0;
    exp_active     = '0;
    if (!m_no_port)
    begin
      exp_hselm           = i_sel_op[m_grant];
      exp_haddrm          = i_addr_op[m_grant];
      exp_htransm         = i_trans_op[m_grant];
      exp_hwritem         = i_write_op[m_grant];
      exp_hsizem          = i_size_op[m_grant];
      exp_hmastlockm      = i_mastlock_op[m_grant];
      exp_active[m_grant] = 1'b1;
    end
    exp_hready  = m_slave_sel ? i_hreadyoutm : 1'b1;
    exp_hwdatam = m_wdata_phase ? i_wdata_op[m_data_port] : '0;
  endfunction

  // Register update at a rising edge
  function automatic void reference_update();
    logic [`NUM_PORTS-1:0] req;
    logic                  hold;
    logic                  xfer;
    int                    win;
    if (!HRESETn)
    begin
      m_grant       = '0;
      m_no_port     = 1'b1;
      m_hsel_lock   = 1'b0;
      m_data_port   = port_idx_t'(3);
      m_wdata_phase = 1'b0;
      m_slave_sel   = 1'b0;
    end
    else
    begin
      reference_outputs();
      if (exp_hready) // Wait state freezes everything
      begin
        for (int i = 0; i < `NUM_PORTS; i++)
          req[i] = i_held_tran_op[i] & i_sel_op[i];
        hold = !m_no_port && req[m_grant] &&
               (i_trans_op[m_grant] == SEQ || i_trans_op[m_grant] == BUSY ||
                (exp_hmastlockm && (m_hsel_lock || exp_hselm)));
        xfer = (exp_htransm == NONSEQ) || (exp_htransm == SEQ);
        win  = -1;
        for (int i = `NUM_PORTS - 1; i >= 0; i--)
          if (req[i])
            win = i; // Lowest index ends up here
        m_data_port   = m_grant; // Address phase moves to data phase
        m_wdata_phase = exp_hselm && xfer;
        m_slave_sel   = exp_hselm;
        if (exp_hselm && xfer && exp_hmastlockm)
          m_hsel_lock = 1'b1;
        else if (!exp_hmastlockm)
          m_hsel_lock = 1'b0;
        if (!hold)
        begin
          if (win >= 0)
          begin
            m_grant   = port_idx_t'(win);
            m_no_port = 1'b0;
          end
          else
            m_no_port = 1'b1; // Grant index kept
        end
      end
    end
  endfunction

  // ----------------------------------------
  // Checking
  // ----------------------------------------
  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    assert (got === exp)
    else
    begin
      $display("MISMATCH %s exp=%h got=%h", name, exp, got);
      err_cnt++;
    end
  endtask

  task automatic compare_outputs();
    check_value("o_hselm", 32'(exp_hselm), 32'(o_hselm));
    check_value("o_haddrm", exp_haddrm, o_haddrm);
    check_value("o_htransm", 32'(exp_htransm), 32'(o_htransm));
    check_value("o_hwritem", 32'(exp_hwritem), 32'(o_hwritem));
    check_value("o_hsizem", 32'(exp_hsizem), 32'(o_hsizem));
    check_value("o_hmastlockm", 32'(exp_hmastlockm), 32'(o_hmastlockm));
    check_value("o_active_op", 32'(exp_active), 32'(o_active_op));
    check_value("o_hreadymuxm", 32'(exp_hready), 32'(o_hreadymuxm));
    check_value("o_hwdatam", exp_hwdatam, o_hwdatam);
    if (have_prev && !prev_ready) // Address side frozen over a wait state
    begin
      check_value("o_haddrm (held)", prev_addr, o_haddrm);
      check_value("o_htransm (held)", 32'(prev_trans), 32'(o_htransm));
      check_value("o_active_op (held)", 32'(prev_active), 32'(o_active_op));
    end
    prev_ready  = exp_hready;
    prev_addr   = o_haddrm;
    prev_trans  = o_htransm;
    prev_active = o_active_op;
    have_prev   = 1'b1;
  endtask

  // Model steps at the edge, compare 1 ns before the next one
  always @(posedge HCLK)
  begin
    reference_update();
    #3;
    if (check_en)
    begin
      reference_outputs();
      compare_outputs();
    end
  end

  always @(posedge HCLK)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run exceeded %0d cycles", TIMEOUT_CYCLES);
      $display("sim failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  task automatic next_cycle();
    @(posedge HCLK);
    #1; // Drive point
  endtask

  task automatic drive_port(input int p, input logic sel, input logic held,
                            input htrans_t trans, input logic lock);
    i_sel_op[p]       = sel;
    i_held_tran_op[p] = held;
    i_trans_op[p]     = trans;
    i_mastlock_op[p]  = lock;
    i_write_op[p]     = 1'b1; // Write traffic only
    i_addr_op[p]      = $random(seed);
    i_size_op[p]      = 3'($random(seed));
    i_wdata_op[p]     = $random(seed);
  endtask

  task automatic idle_port(input int p);
    drive_port(p, 1'b0, 1'b0, IDLE, 1'b0);
  endtask

  task automatic expect_active(input logic [`NUM_PORTS-1:0] exp);
    check_value("o_active_op", 32'(exp), 32'(o_active_op));
  endtask

  task automatic wait_active(input int p, input int limit);
    int cnt;
    cnt = 0;
    while (!o_active_op[p] && cnt < limit)
    begin
      next_cycle();
      cnt++;
    end
    assert (o_active_op[p])
    else
    begin
      $display("Port %0d was not granted within %0d cycles", p, limit);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = err_cnt - test_err_base;
    test_cnt++;
    if (errs == 0)
      $display("test %0d %s: ok", test_cnt, name);
    else
    begin
      $display("test %0d %s: %0d errors", test_cnt, name, errs);
      fail_cnt++;
    end
    test_err_base = err_cnt;
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial
  begin
    HRESETn      = 1'b0;
    i_hreadyoutm = 1'b1;
    for (int p = 0; p < `NUM_PORTS; p++)
      idle_port(p);
    repeat (3) @(posedge HCLK);
    #1;
    HRESETn  = 1'b1;
    check_en = 1'b1;

    // Reset values, then one request from port 1
    expect_active('0);
    check_value("o_hselm", 32'(1'b0), 32'(o_hselm));
    check_value("o_hreadymuxm", 32'(1'b1), 32'(o_hreadymuxm));
    check_value("o_hwdatam", '0, o_hwdatam);
    drive_port(1, 1'b1, 1'b1, NONSEQ, 1'b0);
    next_cycle();
    expect_active(4'b0010); // Granted one clock later
    check_value("o_haddrm", i_addr_op[1], o_haddrm);
    next_cycle();
    idle_port(1);
    repeat (2) next_cycle();
    finish_test("reset and first grant");

    // Ports 3 and 1 together
    drive_port(3, 1'b1, 1'b1, NONSEQ, 1'b0);
    drive_port(1, 1'b1, 1'b1, NONSEQ, 1'b0);
    next_cycle();
    expect_active(4'b0010);
    next_cycle();
    idle_port(1);
    wait_active(3, 4);
    next_cycle();
    idle_port(3);
    repeat (2) next_cycle();
    finish_test("fixed priority");

    // Port 2 burst against port 0
    drive_port(2, 1'b1, 1'b1, NONSEQ, 1'b0);
    next_cycle();
    expect_active(4'b0100);
    drive_port(2, 1'b1, 1'b1, SEQ, 1'b0);
    drive_port(0, 1'b1, 1'b1, NONSEQ, 1'b0);
    next_cycle();
    expect_active(4'b0100);
    drive_port(2, 1'b1, 1'b1, BUSY, 1'b0);
    next_cycle();
    expect_active(4'b0100);
    drive_port(2, 1'b1, 1'b1, SEQ, 1'b0);
    next_cycle();
    expect_active(4'b0100);
    drive_port(2, 1'b1, 1'b1, NONSEQ, 1'b0); // New burst gives up the hold
    next_cycle();
    expect_active(4'b0001);
    idle_port(0);
    idle_port(2);
    repeat (2) next_cycle();
    finish_test("burst hold");

    // Port 3 locked against port 0, with a short HSEL drop
    drive_port(3, 1'b1, 1'b1, NONSEQ, 1'b1);
    next_cycle();
    expect_active(4'b1000);
    drive_port(0, 1'b1, 1'b1, NONSEQ, 1'b0);
    next_cycle();
    expect_active(4'b1000);
    drive_port(3, 1'b1, 1'b1, IDLE, 1'b1); // Locked idle still holds
    next_cycle();
    expect_active(4'b1000);
    drive_port(3, 1'b0, 1'b1, IDLE, 1'b1);
    drive_port(0, 1'b0, 1'b1, NONSEQ, 1'b0); // Both aimed elsewhere
    repeat (2) next_cycle();
    drive_port(3, 1'b1, 1'b1, NONSEQ, 1'b1);
    wait_active(3, 4);
    drive_port(0, 1'b1, 1'b1, NONSEQ, 1'b0);
    drive_port(3, 1'b1, 1'b1, SEQ, 1'b1);
    repeat (2) next_cycle();
    expect_active(4'b1000);
    drive_port(3, 1'b1, 1'b1, NONSEQ, 1'b0); // Lock released
    wait_active(0, 4);
    idle_port(0);
    idle_port(3);
    repeat (2) next_cycle();
    finish_test("locked sequence");

    // Random writes with slave wait states
    repeat (RAND_CYCLES)
    begin
      #1;
      smp_ready = o_hreadymuxm; // Same value the next edge sees
      next_cycle();
      if (smp_ready)
      begin
        for (int p = 0; p < `NUM_PORTS; p++)
          drive_port(p, (($random(seed) & 3) != 0), (($random(seed) & 3) != 0),
                     htrans_t'(2'($random(seed))), (($random(seed) & 7) == 0));
      end
      i_hreadyoutm = (($random(seed) & 3) != 0); // About one wait in four
    end
    i_hreadyoutm = 1'b1;
    next_cycle();
    for (int p = 0; p < `NUM_PORTS; p++)
      idle_port(p);
    repeat (2) next_cycle();
    finish_test("data phase and wait states");

    $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+verilog
verilog/ahb_matrix_pkg.sv
verilog/output_arbiter.sv
verilog/addr_phase_mux.sv
verilog/data_phase_stage.sv
verilog/ahb_output_stage.sv
tests/tb_output_stage.sv

/* run_sim.sh */
#!/bin/sh
# Builds the output-stage testbench with Verilator and runs it.
# The run passes only if the simulator prints the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_output_stage -f project.f -o tb_output_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_output_stage)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1
